// ==== source/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;

    // line geometry
    localparam int LINE_BYTES = 16;
    localparam int LINE_WIDTH = LINE_BYTES * 8;
    localparam int WORDS_PER_LINE = LINE_WIDTH / WORD_WIDTH;

    // address split is tag | index | offset
    localparam int OFFSET_WIDTH = 4;
    localparam int INDEX_WIDTH = 8;
    localparam int NSET = 1 << INDEX_WIDTH;
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    localparam int NWAY = 2;

    // tag word is {dirty, valid, tag}
    localparam int TAG_ENTRY_WIDTH = TAG_WIDTH + 2;

    localparam int VB_DEPTH = 4;
    localparam int LFSR_WIDTH = 16;

    // flat view for memory transfers, word view for select and merge
    typedef union packed {
        logic [LINE_WIDTH-1:0] flat;
        logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] words;
    } line_t;

endpackage

`default_nettype wire

// ==== source/line_ram.sv ====
`default_nettype none

module line_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     ren_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output logic [WIDTH-1:0]         rdata_o,
    input  logic [(WIDTH+7)/8-1:0]   we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  logic [WIDTH-1:0]         wdata_i
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        // output holds while ren_i is low
        if (ren_i) begin
            rdata_o <= mem[raddr_i];
        end
        for (int i = 0; i < WIDTH; i++) begin
            if (we_i[i / 8]) begin
                mem[waddr_i][i] <= wdata_i[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_pipeline.sv ====
`default_nettype none

module dcache_pipeline (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                valid_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0]   addr_i,
    input  logic [dcache_pkg::WORD_WIDTH/8-1:0] wstrb_i,
    input  logic [dcache_pkg::WORD_WIDTH-1:0]   wdata_i,
    output logic                                ready_o,
    output logic                                data_ok_o,
    output logic [dcache_pkg::WORD_WIDTH-1:0]   rdata_o,
    output logic                                refill_req_o,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]   refill_addr_o,
    input  logic                                refill_done_i,
    input  dcache_pkg::line_t                   refill_line_i,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]   vb_lookup_addr_o,
    input  logic                                vb_hit_i,
    input  dcache_pkg::line_t                   vb_hit_line_i,
    output logic                                vb_update_o,
    output dcache_pkg::line_t                   vb_update_line_o,
    input  logic                                vb_full_i,
    output logic                                vb_push_o,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]   vb_push_addr_o,
    output dcache_pkg::line_t                   vb_push_line_o
);
    import dcache_pkg::*;

    localparam int TAG_BYTES = (TAG_ENTRY_WIDTH + 7) / 8;
    localparam int DIRTY_BIT = TAG_ENTRY_WIDTH - 1;
    localparam int VALID_BIT = TAG_ENTRY_WIDTH - 2;

    logic                                 accept;
    logic                                 s2_valid;
    logic [ADDR_WIDTH-1:0]                s2_addr;
    logic [WORD_WIDTH/8-1:0]              s2_wstrb;
    logic [WORD_WIDTH-1:0]                s2_wdata;
    logic [TAG_WIDTH-1:0]                 s2_tag;
    logic [INDEX_WIDTH-1:0]               s2_index;
    logic [OFFSET_WIDTH-3:0]              s2_word;
    logic                                 s2_store;
    logic                                 sweep_busy;
    logic [INDEX_WIDTH-1:0]               sweep_idx;
    logic [INDEX_WIDTH-1:0]               ram_waddr;
    logic [LFSR_WIDTH-1:0]                lfsr;
    logic [NWAY-1:0][TAG_ENTRY_WIDTH-1:0] tag_rdata;
    logic [NWAY-1:0][TAG_ENTRY_WIDTH-1:0] tag_wdata;
    logic [NWAY-1:0]                      tag_we;
    logic [NWAY-1:0]                      way_hit;
    line_t [NWAY-1:0]                     data_rdata;
    line_t [NWAY-1:0]                     data_wdata;
    logic [NWAY-1:0][LINE_BYTES-1:0]      data_we;
    logic                                 hit;
    line_t                                hit_line;
    line_t                                fill_line;
    logic                                 victim;
    logic [TAG_ENTRY_WIDTH-1:0]           victim_entry;

    function automatic line_t merge_store(line_t line, logic [OFFSET_WIDTH-3:0] word,
                                          logic [WORD_WIDTH/8-1:0] strb,
                                          logic [WORD_WIDTH-1:0] data);
        line_t merged;
        merged = line;
        for (int b = 0; b < WORD_WIDTH / 8; b++) begin
            if (strb[b]) begin
                merged.words[word][8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign accept = valid_i && ready_o;
    assign s2_tag = s2_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign s2_index = s2_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign s2_word = s2_addr[OFFSET_WIDTH-1:2];
    assign s2_store = |s2_wstrb;

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        line_ram #(.WIDTH(TAG_ENTRY_WIDTH), .DEPTH(NSET)) i_tag_ram (
            .clk     (clk),
            .ren_i   (accept),
            .raddr_i (addr_i[OFFSET_WIDTH +: INDEX_WIDTH]),
            .rdata_o (tag_rdata[w]),
            .we_i    ({TAG_BYTES{tag_we[w]}}),
            .waddr_i (ram_waddr),
            .wdata_i (tag_wdata[w])
        );
        line_ram #(.WIDTH(LINE_WIDTH), .DEPTH(NSET)) i_data_ram (
            .clk     (clk),
            .ren_i   (accept),
            .raddr_i (addr_i[OFFSET_WIDTH +: INDEX_WIDTH]),
            .rdata_o (data_rdata[w]),
            .we_i    (data_we[w]),
            .waddr_i (ram_waddr),
            .wdata_i (data_wdata[w])
        );
    end

    // stage 2 tag compare with the victim buffer as a third way
    always_comb begin
        hit_line = vb_hit_line_i;
        for (int w = 0; w < NWAY; w++) begin
            way_hit[w] = tag_rdata[w][VALID_BIT] && tag_rdata[w][TAG_WIDTH-1:0] == s2_tag;
            if (way_hit[w]) begin
                hit_line = data_rdata[w];
            end
        end
    end

    assign hit = |way_hit || vb_hit_i;
    assign data_ok_o = s2_valid && (hit || refill_done_i);
    assign fill_line = merge_store(refill_line_i, s2_word, s2_wstrb, s2_wdata);
    assign rdata_o = refill_done_i ? fill_line.words[s2_word] : hit_line.words[s2_word];

    // stall on a miss, on a store that writes the RAMs, and on a full buffer
    assign ready_o = !sweep_busy && !vb_full_i &&
                     !(s2_valid && (!hit || (s2_store && |way_hit)));

    assign refill_addr_o = {s2_addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    assign refill_req_o = s2_valid && !hit && !vb_full_i;
    assign vb_lookup_addr_o = refill_addr_o;

    // store into a line parked in the victim buffer
    assign vb_update_o = s2_valid && s2_store && vb_hit_i;
    assign vb_update_line_o = merge_store(vb_hit_line_i, s2_word, s2_wstrb, s2_wdata);

    assign victim = lfsr[0];
    assign victim_entry = tag_rdata[victim];
    assign vb_push_o = refill_done_i && victim_entry[VALID_BIT] && victim_entry[DIRTY_BIT];
    assign vb_push_addr_o = {victim_entry[TAG_WIDTH-1:0], s2_index, {OFFSET_WIDTH{1'b0}}};
    assign vb_push_line_o = data_rdata[victim];

    assign ram_waddr = sweep_busy ? sweep_idx : s2_index;

    always_comb begin
        for (int w = 0; w < NWAY; w++) begin
            tag_we[w] = 1'b0;
            tag_wdata[w] = {2'b11, s2_tag};
            data_we[w] = '0;
            data_wdata[w] = fill_line;
            if (sweep_busy) begin
                tag_we[w] = 1'b1;
                tag_wdata[w] = '0;
            end else if (refill_done_i && victim == 1'(w)) begin
                tag_we[w] = 1'b1;
                tag_wdata[w] = {s2_store, 1'b1, s2_tag};
                data_we[w] = '1;
            end else if (s2_valid && s2_store && way_hit[w]) begin
                // only the strobed bytes of the addressed word
                tag_we[w] = 1'b1;
                data_we[w] = LINE_BYTES'(s2_wstrb) << {s2_word, 2'b00};
                data_wdata[w] = {WORDS_PER_LINE{s2_wdata}};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
            sweep_busy <= 1'b1;
            sweep_idx <= '0;
            lfsr <= LFSR_WIDTH'(16'hace1);
        end else begin
            s2_valid <= accept || (s2_valid && !data_ok_o);
            // x^16 + x^14 + x^13 + x^11 + 1
            lfsr <= {lfsr[LFSR_WIDTH-2:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            if (sweep_busy) begin
                sweep_idx <= sweep_idx + 1'b1;
                sweep_busy <= sweep_idx != INDEX_WIDTH'(NSET - 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s2_addr <= addr_i;
            s2_wstrb <= wstrb_i;
            s2_wdata <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/victim_buffer.sv ====
`default_nettype none

module victim_buffer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              push_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] push_addr_i,
    input  dcache_pkg::line_t                 push_line_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] lookup_addr_i,
    output logic                              hit_o,
    output dcache_pkg::line_t                 hit_line_o,
    input  logic                              update_i,
    input  dcache_pkg::line_t                 update_line_i,
    output logic                              full_o,
    output logic                              empty_o,
    output logic [dcache_pkg::ADDR_WIDTH-1:0] head_addr_o,
    output dcache_pkg::line_t                 head_line_o,
    input  logic                              pop_i
);
    import dcache_pkg::*;

    localparam int PTR_WIDTH = $clog2(VB_DEPTH);

    logic [VB_DEPTH-1:0]   valid_q;
    logic [PTR_WIDTH-1:0]  head_q;
    logic [PTR_WIDTH-1:0]  tail_q;
    logic [PTR_WIDTH-1:0]  hit_idx;
    logic [ADDR_WIDTH-1:0] addr_q [VB_DEPTH];
    line_t                 line_q [VB_DEPTH];

    // the head entry leaving this cycle no longer answers, so a store
    // to it goes to memory after the write instead of being lost
    always_comb begin
        hit_o = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < VB_DEPTH; i++) begin
            if (valid_q[i] && addr_q[i] == lookup_addr_i &&
                !(pop_i && head_q == PTR_WIDTH'(i))) begin
                hit_o = 1'b1;
                hit_idx = PTR_WIDTH'(i);
            end
        end
    end

    assign hit_line_o = line_q[hit_idx];
    assign full_o = &valid_q;
    assign empty_o = ~|valid_q;
    assign head_addr_o = addr_q[head_q];
    assign head_line_o = line_q[head_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (push_i) begin
                valid_q[tail_q] <= 1'b1;
                tail_q <= tail_q + 1'b1;
            end
            if (pop_i) begin
                valid_q[head_q] <= 1'b0;
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            addr_q[tail_q] <= push_addr_i;
            line_q[tail_q] <= push_line_i;
        end
        if (update_i) begin
            line_q[hit_idx] <= update_line_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_port.sv ====
`default_nettype none

module mem_port (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              refill_req_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] refill_addr_i,
    output logic                              refill_done_o,
    output dcache_pkg::line_t                 refill_line_o,
    input  logic                              vb_empty_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] vb_head_addr_i,
    input  dcache_pkg::line_t                 vb_head_line_i,
    output logic                              vb_pop_o,
    input  logic                              mem_ready_i,
    output logic                              mem_req_o,
    output logic                              mem_we_o,
    output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr_o,
    output logic [dcache_pkg::LINE_WIDTH-1:0] mem_wdata_o,
    input  logic                              mem_rvalid_i,
    input  logic [dcache_pkg::LINE_WIDTH-1:0] mem_rdata_i,
    input  logic                              mem_bvalid_i
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_refill_wait,
        st_drain_wait
    } state_t;

    state_t                state;
    state_t                next_state;
    logic                  start_refill;
    logic                  start_drain;
    logic [LINE_WIDTH-1:0] sent_line;

    // refill first, drain only when no refill is pending
    assign start_refill = state == st_idle && mem_ready_i && refill_req_i;
    assign start_drain = state == st_idle && mem_ready_i && !refill_req_i && !vb_empty_i;

    assign mem_req_o = start_refill || start_drain;
    assign mem_we_o = !refill_req_i;
    assign mem_addr_o = refill_req_i ? refill_addr_i : vb_head_addr_i;
    assign mem_wdata_o = vb_head_line_i.flat;

    assign refill_done_o = state == st_refill_wait && mem_rvalid_i;
    assign refill_line_o.flat = mem_rdata_i;

    // a store may have rewritten the head while its write was out,
    // then it stays queued and is written again
    assign vb_pop_o = state == st_drain_wait && mem_bvalid_i &&
                      vb_head_line_i.flat == sent_line;

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (start_refill) begin
                    next_state = st_refill_wait;
                end else if (start_drain) begin
                    next_state = st_drain_wait;
                end
            end
            st_refill_wait: begin
                if (mem_rvalid_i) begin
                    next_state = st_idle;
                end
            end
            st_drain_wait: begin
                if (mem_bvalid_i) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (start_drain) begin
            sent_line <= vb_head_line_i.flat;
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
`default_nettype none

module dcache_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                valid_i,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0]   addr_i,
    input  logic [dcache_pkg::WORD_WIDTH/8-1:0] wstrb_i,
    input  logic [dcache_pkg::WORD_WIDTH-1:0]   wdata_i,
    output logic                                ready_o,
    output logic                                data_ok_o,
    output logic [dcache_pkg::WORD_WIDTH-1:0]   rdata_o,
    input  logic                                mem_ready_i,
    output logic                                mem_req_o,
    output logic                                mem_we_o,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]   mem_addr_o,
    output logic [dcache_pkg::LINE_WIDTH-1:0]   mem_wdata_o,
    input  logic                                mem_rvalid_i,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]   mem_rdata_i,
    input  logic                                mem_bvalid_i
);
    import dcache_pkg::*;

    // pipeline to memory port
    logic                  refill_req;
    logic [ADDR_WIDTH-1:0] refill_addr;
    logic                  refill_done;
    line_t                 refill_line;

    // pipeline to victim buffer
    logic [ADDR_WIDTH-1:0] vb_lookup_addr;
    logic                  vb_hit;
    line_t                 vb_hit_line;
    logic                  vb_update;
    line_t                 vb_update_line;
    logic                  vb_full;
    logic                  vb_push;
    logic [ADDR_WIDTH-1:0] vb_push_addr;
    line_t                 vb_push_line;

    // victim buffer to memory port
    logic                  vb_empty;
    logic [ADDR_WIDTH-1:0] vb_head_addr;
    line_t                 vb_head_line;
    logic                  vb_pop;

    dcache_pipeline i_pipeline (
        .clk              (clk),
        .rst              (rst),
        .valid_i          (valid_i),
        .addr_i           (addr_i),
        .wstrb_i          (wstrb_i),
        .wdata_i          (wdata_i),
        .ready_o          (ready_o),
        .data_ok_o        (data_ok_o),
        .rdata_o          (rdata_o),
        .refill_req_o     (refill_req),
        .refill_addr_o    (refill_addr),
        .refill_done_i    (refill_done),
        .refill_line_i    (refill_line),
        .vb_lookup_addr_o (vb_lookup_addr),
        .vb_hit_i         (vb_hit),
        .vb_hit_line_i    (vb_hit_line),
        .vb_update_o      (vb_update),
        .vb_update_line_o (vb_update_line),
        .vb_full_i        (vb_full),
        .vb_push_o        (vb_push),
        .vb_push_addr_o   (vb_push_addr),
        .vb_push_line_o   (vb_push_line)
    );

    victim_buffer i_victim_buffer (
        .clk           (clk),
        .rst           (rst),
        .push_i        (vb_push),
        .push_addr_i   (vb_push_addr),
        .push_line_i   (vb_push_line),
        .lookup_addr_i (vb_lookup_addr),
        .hit_o         (vb_hit),
        .hit_line_o    (vb_hit_line),
        .update_i      (vb_update),
        .update_line_i (vb_update_line),
        .full_o        (vb_full),
        .empty_o       (vb_empty),
        .head_addr_o   (vb_head_addr),
        .head_line_o   (vb_head_line),
        .pop_i         (vb_pop)
    );

    mem_port i_mem_port (
        .clk            (clk),
        .rst            (rst),
        .refill_req_i   (refill_req),
        .refill_addr_i  (refill_addr),
        .refill_done_o  (refill_done),
        .refill_line_o  (refill_line),
        .vb_empty_i     (vb_empty),
        .vb_head_addr_i (vb_head_addr),
        .vb_head_line_i (vb_head_line),
        .vb_pop_o       (vb_pop),
        .mem_ready_i    (mem_ready_i),
        .mem_req_o      (mem_req_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .mem_bvalid_i   (mem_bvalid_i)
    );

endmodule

`default_nettype wire

// ==== tb/dcache_assert.sv ====
`default_nettype none

module dcache_assert (
    input logic                              clk,
    input logic                              rst,
    input logic                              valid_i,
    input logic                              ready_i,
    input logic                              data_ok_i,
    input logic                              mem_ready_i,
    input logic                              mem_req_i,
    input logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr_i
);
    import dcache_pkg::*;

    int unsigned fail_count = 0;

    a_req_needs_ready: assert property (@(posedge clk) disable iff (rst)
        mem_req_i |-> mem_ready_i)
        else begin
            fail_count++;
            $error("mem_req_o high while mem_ready_i is low");
        end

    // back to back completions need an accepted request in between
    a_data_ok_single: assert property (@(posedge clk) disable iff (rst)
        data_ok_i && !(valid_i && ready_i) |=> !data_ok_i)
        else begin
            fail_count++;
            $error("data_ok_o high twice without an accepted request");
        end

    a_req_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req_i |-> mem_addr_i[OFFSET_WIDTH-1:0] == '0)
        else begin
            fail_count++;
            $error("mem_addr_o not line aligned");
        end

endmodule

`default_nettype wire

// ==== tb/dcache_tb.sv ====
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    logic                    clk = 1'b0;
    logic                    rst = 1'b1;
    logic                    valid_i = 1'b0;
    logic [ADDR_WIDTH-1:0]   addr_i = '0;
    logic [WORD_WIDTH/8-1:0] wstrb_i = '0;
    logic [WORD_WIDTH-1:0]   wdata_i = '0;
    logic                    ready_o;
    logic                    data_ok_o;
    logic [WORD_WIDTH-1:0]   rdata_o;
    logic                    mem_ready_i = 1'b0;
    logic                    mem_req_o;
    logic                    mem_we_o;
    logic [ADDR_WIDTH-1:0]   mem_addr_o;
    logic [LINE_WIDTH-1:0]   mem_wdata_o;
    logic                    mem_rvalid_i = 1'b0;
    logic [LINE_WIDTH-1:0]   mem_rdata_i = '0;
    logic                    mem_bvalid_i = 1'b0;

    int num_requests = 600;
    int errors = 0;
    int checks = 0;
    int issued_count = 0;
    int done_count = 0;
    bit last_refilled = 1'b0;

    // sparse reference and memory models
    logic [WORD_WIDTH-1:0] ref_words [logic [ADDR_WIDTH-1:0]];
    logic [LINE_WIDTH-1:0] mem_lines [logic [ADDR_WIDTH-1:0]];
    bit                    touched [logic [ADDR_WIDTH-1:0]];

    // outstanding requests in acceptance order
    logic [ADDR_WIDTH-1:0] exp_addr_q [$];
    logic [WORD_WIDTH-1:0] exp_data_q [$];
    bit                    exp_load_q [$];
    bit                    exp_repeat_q [$];
    bit                    exp_refill_q [$];

    // memory side transaction in progress
    bit                    mem_busy = 1'b0;
    bit                    mem_write = 1'b0;
    int                    mem_delay = 0;
    logic [ADDR_WIDTH-1:0] mem_addr = '0;

    dcache_top i_dcache_top (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (valid_i),
        .addr_i       (addr_i),
        .wstrb_i      (wstrb_i),
        .wdata_i      (wdata_i),
        .ready_o      (ready_o),
        .data_ok_o    (data_ok_o),
        .rdata_o      (rdata_o),
        .mem_ready_i  (mem_ready_i),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_bvalid_i (mem_bvalid_i)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // odd multiplier keeps every address bit significant in the initial contents
    function automatic logic [WORD_WIDTH-1:0] init_word(logic [ADDR_WIDTH-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] read_line(logic [ADDR_WIDTH-1:0] line_addr);
        logic [LINE_WIDTH-1:0] line;
        if (mem_lines.exists(line_addr)) begin
            return mem_lines[line_addr];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[WORD_WIDTH*w +: WORD_WIDTH] = init_word(line_addr + 32'(4 * w));
        end
        return line;
    endfunction

    function automatic logic [WORD_WIDTH-1:0] model_word(logic [ADDR_WIDTH-1:0] addr);
        if (ref_words.exists(addr)) begin
            return ref_words[addr];
        end
        return init_word(addr);
    endfunction

    // 4 tags on 4 sets, enough to force conflicts in a 2-way cache
    function automatic logic [ADDR_WIDTH-1:0] random_addr();
        logic [TAG_WIDTH-1:0]   tag;
        logic [INDEX_WIDTH-1:0] index;
        case ($urandom % 4)
            0: tag = 20'h00000;
            1: tag = 20'h00001;
            2: tag = 20'h8a5c3;
            default: tag = 20'hfffff;
        endcase
        case ($urandom % 4)
            0: index = 8'h00;
            1: index = 8'h3c;
            2: index = 8'h3d;
            default: index = 8'hff;
        endcase
        return {tag, index, 2'($urandom % 4), 2'b00};
    endfunction

    function automatic logic [3:0] pick_strobe(int unsigned r);
        case (r % 7)
            0: return 4'b0001;
            1: return 4'b0010;
            2: return 4'b0100;
            3: return 4'b1000;
            4: return 4'b0011;
            5: return 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    // drive one request and hold it until the edge that accepts it
    task automatic issue_request(input logic [ADDR_WIDTH-1:0] addr, input logic [3:0] strb,
                                 input logic [WORD_WIDTH-1:0] data, input bit repeat_check);
        logic [WORD_WIDTH-1:0] word;
        valid_i <= 1'b1;
        addr_i <= addr;
        wstrb_i <= strb;
        wdata_i <= data;
        @(posedge clk);
        while (ready_o !== 1'b1) begin
            @(posedge clk);
        end
        issued_count++;
        touched[addr] = 1'b1;
        word = model_word(addr);
        if (strb != 4'h0) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    word[8*b +: 8] = data[8*b +: 8];
                end
            end
            ref_words[addr] = word;
        end
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(word);
        exp_load_q.push_back(strb == 4'h0);
        exp_repeat_q.push_back(repeat_check);
        exp_refill_q.push_back(1'b0);
    endtask

    task automatic check_repeat_hit(input logic [ADDR_WIDTH-1:0] addr);
        issue_request(addr, 4'h0, '0, 1'b0);
        valid_i <= 1'b0;
        wait (done_count == issued_count);
        // after a refill the line sits in a way, so the same load must hit
        issue_request(addr, 4'h0, '0, last_refilled);
    endtask

    // response monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (mem_req_o === 1'b1 && mem_we_o === 1'b0 && exp_addr_q.size() > 0) begin
                exp_refill_q[0] = 1'b1;
            end
            if (data_ok_o === 1'b1) begin
                if (exp_addr_q.size() == 0) begin
                    errors++;
                    $display("data_ok_o pulsed with no request outstanding");
                end else begin
                    if (exp_load_q[0]) begin
                        checks++;
                        if (rdata_o !== exp_data_q[0]) begin
                            errors++;
                            $display("Mismatch rdata_o at addr %h: got %h, expected %h",
                                     exp_addr_q[0], rdata_o, exp_data_q[0]);
                        end
                    end
                    if (exp_repeat_q[0] && exp_refill_q[0]) begin
                        errors++;
                        $display("repeated load to %h refilled instead of hitting",
                                 exp_addr_q[0]);
                    end
                    last_refilled = exp_refill_q[0];
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_load_q.pop_front());
                    void'(exp_repeat_q.pop_front());
                    void'(exp_refill_q.pop_front());
                    done_count++;
                end
            end
        end
    end

    // memory model with random ready and response delays
    always @(posedge clk) begin
        if (rst) begin
            mem_ready_i <= 1'b0;
            mem_rvalid_i <= 1'b0;
            mem_bvalid_i <= 1'b0;
            mem_busy = 1'b0;
        end else begin
            mem_rvalid_i <= 1'b0;
            mem_bvalid_i <= 1'b0;
            if (mem_req_o === 1'b1) begin
                if (mem_ready_i !== 1'b1 || mem_busy) begin
                    errors++;
                    $display("memory request while the memory was not ready");
                end
                if (mem_addr_o[OFFSET_WIDTH-1:0] !== '0) begin
                    errors++;
                    $display("memory request address %h is not line aligned", mem_addr_o);
                end
                mem_busy = 1'b1;
                mem_write = mem_we_o;
                mem_addr = {mem_addr_o[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
                mem_delay = $urandom_range(8, 1);
                if (mem_we_o) begin
                    mem_lines[mem_addr] = mem_wdata_o;
                end
                mem_ready_i <= 1'b0;
            end else if (mem_busy) begin
                if (mem_delay > 1) begin
                    mem_delay--;
                end else begin
                    mem_busy = 1'b0;
                    if (mem_write) begin
                        mem_bvalid_i <= 1'b1;
                    end else begin
                        mem_rvalid_i <= 1'b1;
                        mem_rdata_i <= read_line(mem_addr);
                    end
                end
            end else begin
                mem_ready_i <= ($urandom % 4) != 0;
            end
        end
    end

    initial begin
        logic [ADDR_WIDTH-1:0] addr;
        logic [3:0]            strb;
        logic [WORD_WIDTH-1:0] data;
        logic [ADDR_WIDTH-1:0] final_addrs [$];
        int                    cycles;
        void'($urandom(7));
        repeat (8) begin
            @(posedge clk);
        end
        rst <= 1'b0;
        // valid bit sweep keeps ready_o low
        cycles = 0;
        @(posedge clk);
        while (ready_o !== 1'b1 && cycles < NSET + 16) begin
            if (data_ok_o !== 1'b0 || mem_req_o !== 1'b0) begin
                errors++;
                $display("data_ok_o or mem_req_o active during the reset sweep");
            end
            @(posedge clk);
            cycles++;
        end
        if (ready_o !== 1'b1) begin
            errors++;
            $display("ready_o did not rise after the reset sweep");
        end
        for (int n = 0; n < num_requests; n++) begin
            addr = random_addr();
            if ($urandom % 2 == 0) begin
                strb = 4'h0;
                data = '0;
            end else begin
                strb = pick_strobe($urandom);
                data = $urandom;
            end
            if (strb == 4'h0 && $urandom % 8 == 0) begin
                check_repeat_hit(addr);
            end else begin
                issue_request(addr, strb, data, 1'b0);
            end
        end
        valid_i <= 1'b0;
        wait (done_count == issued_count);
        wait (i_dcache_top.vb_empty === 1'b1);
        @(posedge clk);
        // read back every touched word
        foreach (touched[a]) begin
            final_addrs.push_back(a);
        end
        foreach (final_addrs[i]) begin
            issue_request(final_addrs[i], 4'h0, '0, 1'b0);
        end
        valid_i <= 1'b0;
        wait (done_count == issued_count);
        @(posedge clk);
        errors = errors + int'(i_dcache_top.i_dcache_assert.fail_count);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog allows 200 cycles per request plus the reset sweep
    initial begin
        repeat ((2 * num_requests + 64) * 200 + NSET + 16) begin
            @(posedge clk);
        end
        $display("timeout with %0d of %0d requests completed", done_count, issued_count);
        $display("%0d checks, %0d errors", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

    bind dcache_top dcache_assert i_dcache_assert (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (valid_i),
        .ready_i     (ready_o),
        .data_ok_i   (data_ok_o),
        .mem_ready_i (mem_ready_i),
        .mem_req_i   (mem_req_o),
        .mem_addr_i  (mem_addr_o)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
source/dcache_pkg.sv
source/line_ram.sv
source/dcache_pipeline.sv
source/victim_buffer.sv
source/mem_port.sv
source/dcache_top.sv
tb/dcache_assert.sv
tb/dcache_tb.sv
